/* flist.f */
+incdir+.
core_pkg.sv
mem_stage.sv
dmem.sv
reg_file.sv
mem_subsys_top.sv
mem_subsys_props.sv
mem_subsys_checker.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_mem_subsys \
  -f flist.f \
  -o sim_mem_subsys

./obj_dir/sim_mem_subsys 2>&1 | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module tb_mem_subsys;

  localparam int TIMEOUT = 50;

  bit                         clk;
  logic                       rst;
  logic                       valid;
  logic [`DATA_WIDTH-1:0]     alu_result;
  logic [`DATA_WIDTH-1:0]     rs2_data;
  logic [`REG_ADDR_WIDTH-1:0] wr_reg;
  logic                       is_load;
  logic                       is_store;
  logic                       reg_wr_en;
  core_pkg::access_size_t     access_size;
  logic [`REG_ADDR_WIDTH-1:0] rd_addr;
  logic                       rd_check;
  logic                       stall;
  logic                       wb_valid;
  logic                       wb_reg_wr_en;
  logic [`REG_ADDR_WIDTH-1:0] wb_wr_reg;
  logic [`DATA_WIDTH-1:0]     wb_data;
  logic [`DATA_WIDTH-1:0]     rd_data;
  int                         err_cnt;
  int                         pending;
  logic [31:0]                lfsr_q;
  int                         tb_errs;
  int                         tests_run;
  int                         tests_failed;

  always #5 clk = ~clk;

  mem_subsys_top i_mem_subsys_top (
    .clk_i          (clk),
    .rst_i          (rst),
    .valid_i        (valid),
    .alu_result_i   (alu_result),
    .rs2_data_i     (rs2_data),
    .wr_reg_i       (wr_reg),
    .is_load_i      (is_load),
    .is_store_i     (is_store),
    .reg_wr_en_i    (reg_wr_en),
    .access_size_i  (access_size),
    .rd_addr_i      (rd_addr),
    .stall_o        (stall),
    .wb_valid_o     (wb_valid),
    .wb_reg_wr_en_o (wb_reg_wr_en),
    .wb_wr_reg_o    (wb_wr_reg),
    .wb_data_o      (wb_data),
    .rd_data_o      (rd_data)
  );

  mem_subsys_checker i_checker (
    .clk_i          (clk),
    .rst_i          (rst),
    .valid_i        (valid),
    .alu_result_i   (alu_result),
    .rs2_data_i     (rs2_data),
    .wr_reg_i       (wr_reg),
    .is_load_i      (is_load),
    .is_store_i     (is_store),
    .reg_wr_en_i    (reg_wr_en),
    .access_size_i  (access_size),
    .rd_addr_i      (rd_addr),
    .rd_check_i     (rd_check),
    .stall_i        (stall),
    .wb_valid_i     (wb_valid),
    .wb_reg_wr_en_i (wb_reg_wr_en),
    .wb_wr_reg_i    (wb_wr_reg),
    .wb_data_i      (wb_data),
    .rd_data_i      (rd_data),
    .err_cnt_o      (err_cnt),
    .pending_o      (pending)
  );

  bind mem_stage mem_subsys_props i_props (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .rd_req_valid_i   (rd_req_valid_o),
    .wr_req_valid_i   (wr_req_valid_o),
    .stall_i          (stall_o),
    .waiting_i        (state_q == WAITING),
    .wb_valid_i       (wb_valid_o)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Loads are held through the stall, then one bubble for the response cycle
  task automatic issue(input logic ld, input logic st, input logic en,
      input logic [`REG_ADDR_WIDTH-1:0] rd, input logic [`DATA_WIDTH-1:0] alu,
      input logic [`DATA_WIDTH-1:0] data, input core_pkg::access_size_t sz);
    int n;
    n = 0;
    @(negedge clk);
    valid       = 1'b1;
    is_load     = ld;
    is_store    = st;
    reg_wr_en   = en;
    wr_reg      = rd;
    alu_result  = alu;
    rs2_data    = data;
    access_size = sz;
    if (ld) begin
      @(negedge clk);
      while (stall && n < TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (stall) begin
        $display("timeout: load to x%0d still stalled after %0d cycles", rd, TIMEOUT);
        tb_errs++;
      end
      valid = 1'b0;
    end
  endtask

  task automatic bubble();
    @(negedge clk);
    valid = 1'b0;
  endtask

  // Kind 0 is an ALU op, 1 a load, 2 a store
  task automatic random_instr(input int kind);
    logic [31:0] alu;
    logic [31:0] data;
    logic [31:0] r;
    logic [31:0] rd;
    core_pkg::access_size_t sz;
    take_bits(32, alu);
    take_bits(32, data);
    take_bits(5, rd);
    take_bits(2, r);
    sz = (r[1:0] == 2'b00) ? core_pkg::SIZE_BYTE :
         (r[1:0] == 2'b01) ? core_pkg::SIZE_HALF : core_pkg::SIZE_WORD;
    take_bits(7, r);
    // Small aligned window so loads hit earlier stores
    if (kind != 0) begin
      case (sz)
        core_pkg::SIZE_BYTE: alu[9:0] = {4'h5, r[5:0]};
        core_pkg::SIZE_HALF: alu[9:0] = {4'h5, r[5:1], 1'b0};
        default:             alu[9:0] = {4'h5, r[5:2], 2'b00};
      endcase
    end
    issue(kind == 1, kind == 2, (kind == 1) || (kind == 0 && r[6]),
          rd[`REG_ADDR_WIDTH-1:0], alu, data, sz);
  endtask

  task automatic store_at(input logic [`ADDR_WIDTH-1:0] addr,
      input core_pkg::access_size_t sz);
    logic [31:0] d;
    take_bits(32, d);
    issue(1'b0, 1'b1, 1'b0, 5'd1, 32'(addr), d, sz);
  endtask

  task automatic load_at(input logic [`REG_ADDR_WIDTH-1:0] rd,
      input logic [`ADDR_WIDTH-1:0] addr, input core_pkg::access_size_t sz);
    issue(1'b1, 1'b0, 1'b1, rd, 32'(addr), '0, sz);
  endtask

  task automatic drain();
    int n;
    n = 0;
    @(negedge clk);
    valid = 1'b0;
    while (pending != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("timeout: %0d write-backs never arrived", pending);
      tb_errs++;
    end
  endtask

  task automatic read_back();
    for (int r = 0; r < `REG_COUNT; r++) begin
      @(negedge clk);
      rd_addr  = `REG_ADDR_WIDTH'(r);
      rd_check = 1'b1;
    end
    @(negedge clk);
    rd_check = 1'b0;
  endtask

  task automatic report_test(input string name, input int mark);
    int errs;
    errs = err_cnt + tb_errs - mark;
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
    end
  endtask

  initial begin
    int          mark;
    logic [31:0] r;
    rst          = 1'b0;
    valid        = 1'b0;
    alu_result   = '0;
    rs2_data     = '0;
    wr_reg       = '0;
    is_load      = 1'b0;
    is_store     = 1'b0;
    reg_wr_en    = 1'b0;
    access_size  = core_pkg::SIZE_WORD;
    rd_addr      = '0;
    rd_check     = 1'b0;
    lfsr_q       = 32'h97eb6184;
    tb_errs      = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    repeat (2) @(negedge clk);

    mark = err_cnt + tb_errs;
    read_back();
    report_test("reset state", mark);

    mark = err_cnt + tb_errs;
    repeat (40) random_instr(0);
    drain();
    read_back();
    report_test("alu write-back", mark);

    mark = err_cnt + tb_errs;
    store_at(10'h080, core_pkg::SIZE_WORD);
    load_at(5'd2, 10'h080, core_pkg::SIZE_WORD);
    load_at(5'd3, 10'h081, core_pkg::SIZE_BYTE);
    load_at(5'd4, 10'h082, core_pkg::SIZE_HALF);
    store_at(10'h082, core_pkg::SIZE_HALF);
    load_at(5'd5, 10'h080, core_pkg::SIZE_WORD);
    store_at(10'h083, core_pkg::SIZE_BYTE);
    load_at(5'd6, 10'h080, core_pkg::SIZE_WORD);
    load_at(5'd7, 10'h082, core_pkg::SIZE_HALF);
    load_at(5'd8, 10'h083, core_pkg::SIZE_BYTE);
    drain();
    read_back();
    report_test("store then load", mark);

    mark = err_cnt + tb_errs;
    repeat (8) random_instr(1);
    drain();
    report_test("load stall timing", mark);

    mark = err_cnt + tb_errs;
    repeat (200) begin
      take_bits(2, r);
      if (r[1:0] == 2'b11) begin
        bubble();
      end else begin
        random_instr(int'(r[1:0]));
      end
    end
    drain();
    read_back();
    report_test("random mix", mark);

    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, err_cnt + tb_errs);
    if (tests_failed == 0 && err_cnt + tb_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule : tb_mem_subsys

/* mem_subsys_checker.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module mem_subsys_checker (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [`DATA_WIDTH-1:0]     alu_result_i,
  input  logic [`DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_reg_i,
  input  logic                       is_load_i,
  input  logic                       is_store_i,
  input  logic                       reg_wr_en_i,
  input  core_pkg::access_size_t     access_size_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_i,
  input  logic                       rd_check_i,
  input  logic                       stall_i,
  input  logic                       wb_valid_i,
  input  logic                       wb_reg_wr_en_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wb_wr_reg_i,
  input  logic [`DATA_WIDTH-1:0]     wb_data_i,
  input  logic [`DATA_WIDTH-1:0]     rd_data_i,
  output int                         err_cnt_o,
  output int                         pending_o
);

  typedef struct packed {
    int                         cycle;
    logic                       wr_en;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]     data;
  } wb_t;

  bit [7:0]               shadow_mem [`MEM_BYTES];
  bit [`DATA_WIDTH-1:0]   shadow_reg [`REG_COUNT];
  wb_t                    exp_q [$];
  wb_t                    exp;
  logic [`ADDR_WIDTH-1:0] a;
  int                     cycle;
  int                     stall_cnt;
  logic                   started;
  logic                   waiting;

  // Write-back value predicted from the shadow state
  function automatic logic [`DATA_WIDTH-1:0] expected_wb(input logic ld,
      input logic [`DATA_WIDTH-1:0] alu, input core_pkg::access_size_t sz);
    logic [`DATA_WIDTH-1:0] v;
    logic [`ADDR_WIDTH-1:0] ad;
    v  = alu;
    ad = alu[`ADDR_WIDTH-1:0];
    if (ld) begin
      v       = '0;
      v[7:0]  = shadow_mem[ad];
      if (sz != core_pkg::SIZE_BYTE) begin
        v[15:8] = shadow_mem[ad + `ADDR_WIDTH'(1)];
      end
      if (sz == core_pkg::SIZE_WORD) begin
        v[23:16] = shadow_mem[ad + `ADDR_WIDTH'(2)];
        v[31:24] = shadow_mem[ad + `ADDR_WIDTH'(3)];
      end
    end
    return v;
  endfunction

  always @(posedge clk_i) begin
    cycle++;
    if (!rst_i) begin
      exp_q.delete();
      started   = 1'b0;
      waiting   = 1'b0;
      err_cnt_o = 0;
      for (int i = 0; i < `REG_COUNT; i++) begin
        shadow_reg[i] = '0;
      end
    end else begin
      if (wb_valid_i && exp_q.size() == 0) begin
        $display("%0t: write-back to x%0d with nothing outstanding", $time, wb_wr_reg_i);
        err_cnt_o++;
      end else if (wb_valid_i) begin
        exp = exp_q.pop_front();
        if (cycle != exp.cycle || wb_reg_wr_en_i !== exp.wr_en ||
            wb_wr_reg_i !== exp.rd || wb_data_i !== exp.data) begin
          $display({"mismatch at %0t: wb x%0d en %0b %h cycle %0d, ",
                    "expected x%0d en %0b %h cycle %0d"},
                   $time, wb_wr_reg_i, wb_reg_wr_en_i, wb_data_i, cycle,
                   exp.rd, exp.wr_en, exp.data, exp.cycle);
          err_cnt_o++;
        end
      end
      if (rd_check_i && rd_data_i !== shadow_reg[rd_addr_i]) begin
        $display("mismatch at %0t: x%0d reads %h, expected %h",
                 $time, rd_addr_i, rd_data_i, shadow_reg[rd_addr_i]);
        err_cnt_o++;
      end
      // One IDLE cycle, then READY, WAITING behind each load
      if (!started) begin
        started = 1'b1;
        if (stall_i) begin
          $display("%0t: stall is high in the cycle after reset", $time);
          err_cnt_o++;
        end
      end else if (waiting && stall_i) begin
        stall_cnt++;
      end else if (waiting) begin
        waiting = 1'b0;
        if (stall_cnt != `DMEM_LATENCY) begin
          $display("mismatch at %0t: load stalled %0d cycles, expected %0d",
                   $time, stall_cnt, `DMEM_LATENCY);
          err_cnt_o++;
        end
      end else if (valid_i) begin
        a          = alu_result_i[`ADDR_WIDTH-1:0];
        exp.cycle  = cycle + (is_load_i ? `DMEM_LATENCY + 1 : 1);
        exp.wr_en  = is_load_i || reg_wr_en_i;
        exp.rd     = wr_reg_i;
        exp.data   = expected_wb(is_load_i, alu_result_i, access_size_i);
        exp_q.push_back(exp);
        if (exp.wr_en && wr_reg_i != '0) begin
          shadow_reg[wr_reg_i] = exp.data;
        end
        if (is_store_i && !is_load_i) begin
          shadow_mem[a] = rs2_data_i[7:0];
          if (access_size_i != core_pkg::SIZE_BYTE) begin
            shadow_mem[a + `ADDR_WIDTH'(1)] = rs2_data_i[15:8];
          end
          if (access_size_i == core_pkg::SIZE_WORD) begin
            shadow_mem[a + `ADDR_WIDTH'(2)] = rs2_data_i[23:16];
            shadow_mem[a + `ADDR_WIDTH'(3)] = rs2_data_i[31:24];
          end
        end
        waiting   = is_load_i;
        stall_cnt = stall_i ? 1 : 0;
        if (stall_i && !is_load_i) begin
          $display("%0t: stall is high for an instruction that is not a load", $time);
          err_cnt_o++;
        end
      end else if (stall_i) begin
        $display("%0t: stall is high with no load presented", $time);
        err_cnt_o++;
      end
    end
    pending_o = exp_q.size();
  end

endmodule : mem_subsys_checker

/* mem_subsys_props.sv */
`timescale 1ns/1ps

module mem_subsys_props (
  input logic clk_i,
  input logic rst_i,
  input logic rd_req_valid_i,
  input logic wr_req_valid_i,
  input logic stall_i,
  input logic waiting_i,
  input logic wb_valid_i
);

  // A read and a write never share a cycle
  req_exclusive: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(rd_req_valid_i && wr_req_valid_i))
    else $error("read and write request in the same cycle");

  // Stall raised with the load stays up into every waiting cycle
  stall_while_waiting: assert property (@(posedge clk_i) disable iff (!rst_i)
    waiting_i |-> $past(stall_i))
    else $error("stall dropped while a load is still pending");

  // Load result is registered right after the stall is released
  wb_after_release: assert property (@(posedge clk_i) disable iff (!rst_i)
    $fell(stall_i) |=> wb_valid_i)
    else $error("no write-back in the cycle after the stall was released");

endmodule : mem_subsys_props

/* mem_subsys_top.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module mem_subsys_top (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [`DATA_WIDTH-1:0]     alu_result_i,
  input  logic [`DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_reg_i,
  input  logic                       is_load_i,
  input  logic                       is_store_i,
  input  logic                       reg_wr_en_i,
  input  core_pkg::access_size_t     access_size_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_i,
  output logic                       stall_o,
  output logic                       wb_valid_o,
  output logic                       wb_reg_wr_en_o,
  output logic [`REG_ADDR_WIDTH-1:0] wb_wr_reg_o,
  output logic [`DATA_WIDTH-1:0]     wb_data_o,
  output logic [`DATA_WIDTH-1:0]     rd_data_o
);

  // Stage to memory
  logic                   rd_req_valid;
  logic                   wr_req_valid;
  logic [`ADDR_WIDTH-1:0] req_address;
  logic [`DATA_WIDTH-1:0] wr_data;
  core_pkg::access_size_t req_access_size;
  logic [`DATA_WIDTH-1:0] mem_data;
  logic                   mem_data_valid;

  // Stage to register file
  logic                   wb_is_load;
  logic [`DATA_WIDTH-1:0] wb_alu_result;
  logic [`DATA_WIDTH-1:0] wb_mem_data;

  mem_stage i_mem_stage (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .valid_i           (valid_i),
    .alu_result_i      (alu_result_i),
    .rs2_data_i        (rs2_data_i),
    .wr_reg_i          (wr_reg_i),
    .is_load_i         (is_load_i),
    .is_store_i        (is_store_i),
    .reg_wr_en_i       (reg_wr_en_i),
    .access_size_i     (access_size_i),
    .mem_data_i        (mem_data),
    .mem_data_valid_i  (mem_data_valid),
    .stall_o           (stall_o),
    .rd_req_valid_o    (rd_req_valid),
    .wr_req_valid_o    (wr_req_valid),
    .mem_req_address_o (req_address),
    .wr_data_o         (wr_data),
    .req_access_size_o (req_access_size),
    .wb_valid_o        (wb_valid_o),
    .wb_reg_wr_en_o    (wb_reg_wr_en_o),
    .wb_is_load_o      (wb_is_load),
    .wb_wr_reg_o       (wb_wr_reg_o),
    .wb_alu_result_o   (wb_alu_result),
    .wb_mem_data_o     (wb_mem_data)
  );

  dmem i_dmem (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .rd_req_valid_i    (rd_req_valid),
    .wr_req_valid_i    (wr_req_valid),
    .req_address_i     (req_address),
    .wr_data_i         (wr_data),
    .req_access_size_i (req_access_size),
    .mem_data_o        (mem_data),
    .mem_data_valid_o  (mem_data_valid)
  );

  reg_file i_reg_file (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wb_valid_i      (wb_valid_o),
    .wb_reg_wr_en_i  (wb_reg_wr_en_o),
    .wb_is_load_i    (wb_is_load),
    .wb_wr_reg_i     (wb_wr_reg_o),
    .wb_alu_result_i (wb_alu_result),
    .wb_mem_data_i   (wb_mem_data),
    .rd_addr_i       (rd_addr_i),
    .wb_data_o       (wb_data_o),
    .rd_data_o       (rd_data_o)
  );

endmodule : mem_subsys_top

/* reg_file.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_file (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       wb_valid_i,
  input  logic                       wb_reg_wr_en_i,
  input  logic                       wb_is_load_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wb_wr_reg_i,
  input  logic [`DATA_WIDTH-1:0]     wb_alu_result_i,
  input  logic [`DATA_WIDTH-1:0]     wb_mem_data_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_i,
  output logic [`DATA_WIDTH-1:0]     wb_data_o,
  output logic [`DATA_WIDTH-1:0]     rd_data_o
);

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  logic wr_en;

  assign wb_data_o = wb_is_load_i ? wb_mem_data_i : wb_alu_result_i;

  // Register zero is never written
  assign wr_en = wb_valid_i && wb_reg_wr_en_i && (wb_wr_reg_i != '0);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_wr_reg_i] <= wb_data_o;
    end
  end

  assign rd_data_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

endmodule : reg_file

/* dmem.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module dmem (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   rd_req_valid_i,
  input  logic                   wr_req_valid_i,
  input  logic [`ADDR_WIDTH-1:0] req_address_i,
  input  logic [`DATA_WIDTH-1:0] wr_data_i,
  input  core_pkg::access_size_t req_access_size_i,
  output logic [`DATA_WIDTH-1:0] mem_data_o,
  output logic                   mem_data_valid_o
);

  logic [7:0] mem [`MEM_BYTES];

  // Byte lanes, little endian, wrapping at the top
  logic [`ADDR_WIDTH-1:0] addr_b1;
  logic [`ADDR_WIDTH-1:0] addr_b2;
  logic [`ADDR_WIDTH-1:0] addr_b3;

  logic [`DATA_WIDTH-1:0] rd_data;

  logic [`DMEM_LATENCY-1:0] rd_valid_q;
  logic [`DATA_WIDTH-1:0]   rd_data_q [`DMEM_LATENCY];

  assign addr_b1 = req_address_i + `ADDR_WIDTH'(1);
  assign addr_b2 = req_address_i + `ADDR_WIDTH'(2);
  assign addr_b3 = req_address_i + `ADDR_WIDTH'(3);

  initial begin
    for (int i = 0; i < `MEM_BYTES; i++) begin
      mem[i] = 8'h00;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_req_valid_i) begin
      mem[req_address_i] <= wr_data_i[7:0];
      if (req_access_size_i != core_pkg::SIZE_BYTE) begin
        mem[addr_b1] <= wr_data_i[15:8];
      end
      if (req_access_size_i == core_pkg::SIZE_WORD) begin
        mem[addr_b2] <= wr_data_i[23:16];
        mem[addr_b3] <= wr_data_i[31:24];
      end
    end
  end

  // Zero-extended read of the addressed bytes
  always_comb begin
    rd_data       = '0;
    rd_data[7:0]  = mem[req_address_i];
    if (req_access_size_i != core_pkg::SIZE_BYTE) begin
      rd_data[15:8] = mem[addr_b1];
    end
    if (req_access_size_i == core_pkg::SIZE_WORD) begin
      rd_data[23:16] = mem[addr_b2];
      rd_data[31:24] = mem[addr_b3];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rd_valid_q <= '0;
    end else begin
      rd_valid_q[0] <= rd_req_valid_i;
      for (int i = 1; i < `DMEM_LATENCY; i++) begin
        rd_valid_q[i] <= rd_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rd_data_q[0] <= rd_data;
    for (int i = 1; i < `DMEM_LATENCY; i++) begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
  end

  assign mem_data_valid_o = rd_valid_q[`DMEM_LATENCY-1];
  assign mem_data_o       = rd_data_q[`DMEM_LATENCY-1];

endmodule : dmem

/* mem_stage.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module mem_stage (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       valid_i,
  input  logic [`DATA_WIDTH-1:0]     alu_result_i,
  input  logic [`DATA_WIDTH-1:0]     rs2_data_i,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_reg_i,
  input  logic                       is_load_i,
  input  logic                       is_store_i,
  input  logic                       reg_wr_en_i,
  input  core_pkg::access_size_t     access_size_i,
  input  logic [`DATA_WIDTH-1:0]     mem_data_i,
  input  logic                       mem_data_valid_i,
  output logic                       stall_o,
  output logic                       rd_req_valid_o,
  output logic                       wr_req_valid_o,
  output logic [`ADDR_WIDTH-1:0]     mem_req_address_o,
  output logic [`DATA_WIDTH-1:0]     wr_data_o,
  output core_pkg::access_size_t     req_access_size_o,
  output logic                       wb_valid_o,
  output logic                       wb_reg_wr_en_o,
  output logic                       wb_is_load_o,
  output logic [`REG_ADDR_WIDTH-1:0] wb_wr_reg_o,
  output logic [`DATA_WIDTH-1:0]     wb_alu_result_o,
  output logic [`DATA_WIDTH-1:0]     wb_mem_data_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state_q;
  state_t state_d;

  logic accept;
  logic load_done;

  // Destination and address of the load in flight
  logic [`REG_ADDR_WIDTH-1:0] pend_wr_reg_q;
  logic [`DATA_WIDTH-1:0]     pend_alu_q;

  assign accept    = (state_q == READY) && valid_i;
  assign load_done = (state_q == WAITING) && mem_data_valid_i;

  // Requests go out in the acceptance cycle
  assign mem_req_address_o = alu_result_i[`ADDR_WIDTH-1:0];
  assign wr_data_o         = rs2_data_i;
  assign req_access_size_o = access_size_i;
  assign rd_req_valid_o    = accept && is_load_i;
  assign wr_req_valid_o    = accept && is_store_i && !is_load_i;

  always_comb begin
    state_d = state_q;
    stall_o = 1'b0;
    case (state_q)
      IDLE: begin
        state_d = READY;
      end
      READY: begin
        if (accept && is_load_i) begin
          stall_o = 1'b1;
          state_d = WAITING;
        end
      end
      WAITING: begin
        // Released in the cycle the response shows up
        stall_o = !mem_data_valid_i;
        if (mem_data_valid_i) begin
          state_d = READY;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q        <= IDLE;
      wb_valid_o     <= 1'b0;
      wb_reg_wr_en_o <= 1'b0;
      wb_is_load_o   <= 1'b0;
    end else begin
      state_q        <= state_d;
      wb_valid_o     <= (accept && !is_load_i) || load_done;
      // Completed loads always write their register
      wb_reg_wr_en_o <= (accept && !is_load_i && reg_wr_en_i) || load_done;
      wb_is_load_o   <= load_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_load_i) begin
      pend_wr_reg_q <= wr_reg_i;
      pend_alu_q    <= alu_result_i;
    end
    if (accept && !is_load_i) begin
      wb_wr_reg_o     <= wr_reg_i;
      wb_alu_result_o <= alu_result_i;
    end else if (load_done) begin
      wb_wr_reg_o     <= pend_wr_reg_q;
      wb_alu_result_o <= pend_alu_q;
      wb_mem_data_o   <= mem_data_i;
    end
  end

endmodule : mem_stage

/* core_pkg.sv */
package core_pkg;

  // Width of a load or store access
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_t;

endpackage : core_pkg

/* core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Datapath and address widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 10

// Architectural register file
`define REG_COUNT      32
`define REG_ADDR_WIDTH 5

// Data memory size in bytes
`define MEM_BYTES 1024

// Read request to response, at least 1
`define DMEM_LATENCY 2

`endif
